// File: fmc_consts.svh
`ifndef FMC_CONSTS_SVH
`define FMC_CONSTS_SVH

// ==================================================
// FMC PSRAM slave geometry
// ==================================================

// Address bus width, in 16-bit words
`define FMC_ADDR_WIDTH 12

// Data bus width
`define FMC_DATA_WIDTH 16

// Ticks after the address tick before the first write word is on the bus
`define FMC_DATLAT 2

// Depth of the internal RAM, one word per address
`define FMC_MEM_WORDS 4096

`endif

// File: fmc_pkg.sv
`include "fmc_consts.svh"

package fmc_pkg;

    // Word address on the FMC bus and into the RAM
    typedef logic [`FMC_ADDR_WIDTH-1:0] fmc_addr_t;

    // One data word
    typedef logic [`FMC_DATA_WIDTH-1:0] fmc_data_t;

    // Byte lanes, one bit each
    typedef logic [`FMC_DATA_WIDTH/8-1:0] fmc_be_t;

    // Ticks since the address tick
    typedef logic [7:0] fmc_tick_t;

    // Burst phase
    typedef enum logic [1:0] {
        IDLE,
        ADDR,
        LATENCY,
        DATA
    } burst_state_t;

endpackage

// File: fmc_burst_decode.sv
`include "fmc_consts.svh"

module fmc_burst_decode (
    input  logic               FMC_CLK_s,
    input  logic               FMC_NE,
    input  logic               FMC_NL,
    input  logic               FMC_NWE,
    input  fmc_pkg::fmc_addr_t FMC_A,
    output fmc_pkg::fmc_tick_t tick,
    output fmc_pkg::fmc_addr_t start_addr,
    output logic               addr_load,
    output logic               is_write,
    output logic               data_phase
);

    localparam fmc_pkg::fmc_tick_t DATLAT = fmc_pkg::fmc_tick_t'(`FMC_DATLAT);

    fmc_pkg::burst_state_t state;
    fmc_pkg::burst_state_t state_nxt;
    fmc_pkg::fmc_tick_t    tick_nxt;
    logic                  addr_tick;

    // The one edge with NL low while idle
    assign addr_tick = (state == fmc_pkg::IDLE) && !FMC_NL;
    assign tick_nxt  = tick + 1'b1;

    // ==================================================
    // Tick counter
    // ==================================================

    // Holds all ones until the address tick, then reads 0 during tick 0
    always_ff @(posedge FMC_CLK_s or posedge FMC_NE) begin
        if (FMC_NE) begin
            tick <= '1;
        end else if (state != fmc_pkg::IDLE || addr_tick) begin
            tick <= tick_nxt;
        end
    end

    // ==================================================
    // Burst phase FSM
    // ==================================================

    always_comb begin
        state_nxt = state;
        case (state)
            fmc_pkg::IDLE: begin
                if (!FMC_NL) begin
                    state_nxt = fmc_pkg::ADDR;
                end
            end
            fmc_pkg::ADDR, fmc_pkg::LATENCY: begin
                // Phase of the tick that the coming edge starts
                state_nxt = (tick_nxt >= DATLAT) ? fmc_pkg::DATA : fmc_pkg::LATENCY;
            end
            default: begin
                state_nxt = fmc_pkg::DATA;
            end
        endcase
    end

    always_ff @(posedge FMC_CLK_s or posedge FMC_NE) begin
        if (FMC_NE) begin
            state <= fmc_pkg::IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // Direction is fixed for the whole burst
    always_ff @(posedge FMC_CLK_s or posedge FMC_NE) begin
        if (FMC_NE) begin
            is_write <= 1'b0;
        end else if (addr_tick) begin
            is_write <= !FMC_NWE;
        end
    end

    always_ff @(posedge FMC_CLK_s) begin
        if (addr_tick) begin
            start_addr <= FMC_A;
        end
    end

    // Counter loads from start_addr at the edge that ends tick 0
    assign addr_load = (state == fmc_pkg::ADDR);

    // Looks one tick ahead, so it is high at every edge from tick DATLAT on
    assign data_phase = is_write && (state_nxt == fmc_pkg::DATA);

    a_idle_in_reset: assert property (@(posedge FMC_CLK_s)
        FMC_NE |-> (state == fmc_pkg::IDLE));

endmodule

// File: fmc_bram_access.sv
module fmc_bram_access (
    input  logic               FMC_CLK_s,
    input  logic               FMC_NE,
    input  fmc_pkg::fmc_addr_t start_addr,
    input  logic               addr_load,
    input  logic               is_write,
    input  logic               data_phase,
    input  fmc_pkg::fmc_data_t FMC_D_I,
    input  fmc_pkg::fmc_be_t   FMC_NBL,
    output fmc_pkg::fmc_addr_t bram_addr,
    output logic               bram_en,
    output fmc_pkg::fmc_be_t   bram_we,
    output fmc_pkg::fmc_data_t bram_din
);

    logic wr_started;
    logic addr_step;

    // Set once the first write word has been captured
    always_ff @(posedge FMC_CLK_s or posedge FMC_NE) begin
        if (FMC_NE) begin
            wr_started <= 1'b0;
        end else if (data_phase) begin
            wr_started <= 1'b1;
        end
    end

    // Reads stream every tick, writes step once per word after the first
    assign addr_step = is_write ? (data_phase && wr_started) : 1'b1;

    // Wraps modulo the memory depth
    always_ff @(posedge FMC_CLK_s) begin
        if (addr_load) begin
            bram_addr <= start_addr;
        end else if (addr_step) begin
            bram_addr <= bram_addr + 1'b1;
        end
    end

    always_ff @(posedge FMC_CLK_s or posedge FMC_NE) begin
        if (FMC_NE) begin
            bram_en <= 1'b0;
        end else begin
            bram_en <= 1'b1;
        end
    end

    // Lanes are active low on the bus
    // The RAM writes at the edge after capture, so NE must stay low one more edge
    always_ff @(posedge FMC_CLK_s or posedge FMC_NE) begin
        if (FMC_NE) begin
            bram_we <= '0;
        end else begin
            bram_we <= data_phase ? ~FMC_NBL : '0;
        end
    end

    always_ff @(posedge FMC_CLK_s) begin
        if (data_phase) begin
            bram_din <= FMC_D_I;
        end
    end

    a_we_needs_en: assert property (@(posedge FMC_CLK_s) (|bram_we) |-> bram_en);

endmodule

// File: fmc_read_return.sv
`include "fmc_consts.svh"

module fmc_read_return (
    input  logic               FMC_CLK_s,
    input  logic               FMC_NE,
    input  logic               FMC_NOE,
    input  logic               is_write,
    input  fmc_pkg::fmc_tick_t tick,
    input  fmc_pkg::fmc_data_t bram_dout,
    output fmc_pkg::fmc_data_t FMC_D_O,
    output fmc_pkg::fmc_data_t FMC_D_T,
    output logic               FMC_NWAIT
);

    logic rd_ready;

    // All ones means no address tick yet
    assign rd_ready = !is_write && (tick != '1)
                      && (tick >= fmc_pkg::fmc_tick_t'(`FMC_DATLAT));

    // Sticky for the rest of the burst, high from tick DATLAT+1 on
    always_ff @(posedge FMC_CLK_s or posedge FMC_NE) begin
        if (FMC_NE) begin
            FMC_NWAIT <= 1'b0;
        end else begin
            FMC_NWAIT <= FMC_NWAIT || rd_ready;
        end
    end

    // Output register, first word lands here on the edge NWAIT rises
    always_ff @(posedge FMC_CLK_s) begin
        FMC_D_O <= bram_dout;
    end

    assign FMC_D_T = {`FMC_DATA_WIDTH{FMC_NOE}};

    a_nwait_off_at_end: assert property (@(posedge FMC_CLK_s)
        $rose(FMC_NE) |-> !FMC_NWAIT);

endmodule

// File: psram_bram.sv
`include "fmc_consts.svh"

module psram_bram (
    input  logic               FMC_CLK_s,
    input  logic               bram_en,
    input  fmc_pkg::fmc_be_t   bram_we,
    input  fmc_pkg::fmc_addr_t bram_addr,
    input  fmc_pkg::fmc_data_t bram_din,
    output fmc_pkg::fmc_data_t bram_dout
);

    localparam int LANES = `FMC_DATA_WIDTH / 8;

    fmc_pkg::fmc_data_t mem [`FMC_MEM_WORDS];

    // Power-up contents are zero
    initial begin
        for (int i = 0; i < `FMC_MEM_WORDS; i++) begin
            mem[i] = '0;
        end
    end

    // ==================================================
    // Single port, read before write
    // ==================================================

    always_ff @(posedge FMC_CLK_s) begin
        if (bram_en) begin
            bram_dout <= mem[bram_addr];
        end
    end

    // Each byte lane written on its own enable
    always_ff @(posedge FMC_CLK_s) begin
        for (int b = 0; b < LANES; b++) begin
            if (bram_en && bram_we[b]) begin
                mem[bram_addr][8*b +: 8] <= bram_din[8*b +: 8];
            end
        end
    end

endmodule

// File: fmc_psram_top.sv
module fmc_psram_top (
    input  logic               FMC_CLK_s,
    input  logic               FMC_NE,
    input  logic               FMC_NL,
    input  logic               FMC_NOE,
    input  logic               FMC_NWE,
    input  fmc_pkg::fmc_addr_t FMC_A,
    input  fmc_pkg::fmc_data_t FMC_D_I,
    input  fmc_pkg::fmc_be_t   FMC_NBL,
    output fmc_pkg::fmc_data_t FMC_D_O,
    output fmc_pkg::fmc_data_t FMC_D_T,
    output logic               FMC_NWAIT
);

    // Decode to execute and result
    fmc_pkg::fmc_tick_t tick;
    fmc_pkg::fmc_addr_t start_addr;
    logic               addr_load;
    logic               is_write;
    logic               data_phase;

    // Execute to RAM
    fmc_pkg::fmc_addr_t bram_addr;
    logic               bram_en;
    fmc_pkg::fmc_be_t   bram_we;
    fmc_pkg::fmc_data_t bram_din;
    fmc_pkg::fmc_data_t bram_dout;

    fmc_burst_decode u_decode (
        .FMC_CLK_s (FMC_CLK_s),
        .FMC_NE    (FMC_NE),
        .FMC_NL    (FMC_NL),
        .FMC_NWE   (FMC_NWE),
        .FMC_A     (FMC_A),
        .tick      (tick),
        .start_addr(start_addr),
        .addr_load (addr_load),
        .is_write  (is_write),
        .data_phase(data_phase)
    );

    fmc_bram_access u_access (
        .FMC_CLK_s (FMC_CLK_s),
        .FMC_NE    (FMC_NE),
        .start_addr(start_addr),
        .addr_load (addr_load),
        .is_write  (is_write),
        .data_phase(data_phase),
        .FMC_D_I   (FMC_D_I),
        .FMC_NBL   (FMC_NBL),
        .bram_addr (bram_addr),
        .bram_en   (bram_en),
        .bram_we   (bram_we),
        .bram_din  (bram_din)
    );

    psram_bram u_ram (
        .FMC_CLK_s(FMC_CLK_s),
        .bram_en  (bram_en),
        .bram_we  (bram_we),
        .bram_addr(bram_addr),
        .bram_din (bram_din),
        .bram_dout(bram_dout)
    );

    fmc_read_return u_return (
        .FMC_CLK_s(FMC_CLK_s),
        .FMC_NE   (FMC_NE),
        .FMC_NOE  (FMC_NOE),
        .is_write (is_write),
        .tick     (tick),
        .bram_dout(bram_dout),
        .FMC_D_O  (FMC_D_O),
        .FMC_D_T  (FMC_D_T),
        .FMC_NWAIT(FMC_NWAIT)
    );

endmodule

// File: tb_clk_gen.sv
module tb_clk_gen (
    output logic clk
);

    timeunit 1ns;
    timeprecision 100ps;

    localparam realtime HALF_PERIOD = 4ns;

    // Free running, 8 ns period
    initial begin
        clk = 1'b0;
        forever begin
            #(HALF_PERIOD) clk = ~clk;
        end
    end

endmodule

// File: tb_fmc_psram.sv
`include "fmc_consts.svh"

module tb_fmc_psram;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_BURSTS      = 18;
    localparam int RESET_CYCLES    = 5;
    localparam int WATCHDOG_MARGIN = 100;
    localparam int READ_WAIT_LIMIT = 16;

    typedef struct packed {
        logic               is_write;
        fmc_pkg::fmc_addr_t addr;
        int                 len;
        fmc_pkg::fmc_be_t   lanes;
        logic               rnd;
    } burst_t;

    logic               FMC_CLK_s;
    logic               FMC_NE;
    logic               FMC_NL;
    logic               FMC_NOE;
    logic               FMC_NWE;
    fmc_pkg::fmc_addr_t FMC_A;
    fmc_pkg::fmc_data_t FMC_D_I;
    fmc_pkg::fmc_be_t   FMC_NBL;
    fmc_pkg::fmc_data_t FMC_D_O;
    fmc_pkg::fmc_data_t FMC_D_T;
    logic               FMC_NWAIT;

    burst_t             bursts [NUM_BURSTS];
    fmc_pkg::fmc_data_t ref_mem [`FMC_MEM_WORDS];
    int                 watchdog_cycles = 0;

    tb_clk_gen u_clk_gen (
        .clk(FMC_CLK_s)
    );

    fmc_psram_top u_fmc_psram (
        .FMC_CLK_s(FMC_CLK_s),
        .FMC_NE   (FMC_NE),
        .FMC_NL   (FMC_NL),
        .FMC_NOE  (FMC_NOE),
        .FMC_NWE  (FMC_NWE),
        .FMC_A    (FMC_A),
        .FMC_D_I  (FMC_D_I),
        .FMC_NBL  (FMC_NBL),
        .FMC_D_O  (FMC_D_O),
        .FMC_D_T  (FMC_D_T),
        .FMC_NWAIT(FMC_NWAIT)
    );

    // ==================================================
    // Helpers
    // ==================================================

    task automatic report_fail(input string msg);
        $display("%s", msg);
        $display("TB FAILED");
        $fatal(1, "stopping at first error");
    endtask

    function automatic fmc_pkg::fmc_data_t fixed_word(input int idx,
                                                      input fmc_pkg::fmc_addr_t a);
        return {4'(idx) ^ 4'hA, a};
    endfunction

    function automatic void set_burst(input int idx, input logic w, input fmc_pkg::fmc_addr_t a,
                                      input int len, input fmc_pkg::fmc_be_t lanes,
                                      input logic rnd);
        bursts[idx].is_write = w;
        bursts[idx].addr     = a;
        bursts[idx].len      = len;
        bursts[idx].lanes    = lanes;
        bursts[idx].rnd      = rnd;
    endfunction

    // Reference copy updated lane by lane
    function automatic void store_reference(input fmc_pkg::fmc_addr_t a,
                                            input fmc_pkg::fmc_data_t word,
                                            input fmc_pkg::fmc_be_t lanes);
        for (int b = 0; b < `FMC_DATA_WIDTH / 8; b++) begin
            if (lanes[b]) begin
                ref_mem[a][8*b +: 8] = word[8*b +: 8];
            end
        end
    endfunction

    // Pin rules that hold on every falling edge
    task automatic check_pin_rules(input logic nwait_must_be_low);
        fmc_pkg::fmc_data_t d_t_exp;
        d_t_exp = FMC_NOE ? '1 : '0;
        assert (FMC_D_T === d_t_exp) else begin
            report_fail($sformatf("FAIL FMC_D_T got 0x%h expected 0x%h", FMC_D_T, d_t_exp));
        end
        if (FMC_NE || nwait_must_be_low) begin
            assert (FMC_NWAIT === 1'b0) else begin
                report_fail($sformatf("FAIL FMC_NWAIT got 0x%h expected 0x0", FMC_NWAIT));
            end
        end
    endtask

    // ==================================================
    // Host bus driver
    // ==================================================

    task automatic apply_write_burst(input int idx);
        fmc_pkg::fmc_addr_t a;
        fmc_pkg::fmc_addr_t wa;
        fmc_pkg::fmc_data_t word;
        a = bursts[idx].addr;
        @(negedge FMC_CLK_s);
        check_pin_rules(1'b1);
        FMC_NE  = 1'b0;
        FMC_NL  = 1'b0;
        FMC_A   = a;
        FMC_NWE = 1'b0;
        FMC_NOE = 1'b1;
        @(negedge FMC_CLK_s);
        check_pin_rules(1'b1);
        FMC_NL = 1'b1;
        // First word sits on the bus at the edge of tick DATLAT
        for (int k = 0; k < bursts[idx].len; k++) begin
            @(negedge FMC_CLK_s);
            check_pin_rules(1'b1);
            wa      = fmc_pkg::fmc_addr_t'(a + k);
            word    = bursts[idx].rnd ? fmc_pkg::fmc_data_t'($urandom) : fixed_word(idx, wa);
            FMC_D_I = word;
            FMC_NBL = ~bursts[idx].lanes;
            store_reference(wa, word, bursts[idx].lanes);
        end
        @(negedge FMC_CLK_s);
        check_pin_rules(1'b1);
        FMC_NBL = '1;
        FMC_D_I = '0;
        // One more edge so the last captured word reaches the RAM
        @(negedge FMC_CLK_s);
        check_pin_rules(1'b1);
        FMC_NE  = 1'b1;
        FMC_NWE = 1'b1;
    endtask

    task automatic apply_read_burst(input int idx);
        fmc_pkg::fmc_addr_t a;
        fmc_pkg::fmc_data_t exp_word;
        int                 k;
        int                 cyc;
        a   = bursts[idx].addr;
        k   = 0;
        cyc = 0;
        @(negedge FMC_CLK_s);
        check_pin_rules(1'b0);
        FMC_NE  = 1'b0;
        FMC_NL  = 1'b0;
        FMC_A   = a;
        FMC_NWE = 1'b1;
        FMC_NOE = 1'b0;
        @(negedge FMC_CLK_s);
        cyc = 1;
        check_pin_rules(1'b0);
        FMC_NL = 1'b1;
        while (k < bursts[idx].len) begin
            @(negedge FMC_CLK_s);
            cyc++;
            check_pin_rules(1'b0);
            if (FMC_NWAIT) begin
                // NWAIT rises at the edge of tick DATLAT+1
                if (k == 0) begin
                    assert (cyc == `FMC_DATLAT + 2) else begin
                        report_fail($sformatf(
                            "FAIL FMC_NWAIT first high at cycle 0x%h expected 0x%h",
                            cyc, `FMC_DATLAT + 2));
                    end
                end
                exp_word = ref_mem[fmc_pkg::fmc_addr_t'(a + k)];
                assert (FMC_D_O === exp_word) else begin
                    report_fail($sformatf("FAIL FMC_D_O at addr 0x%h got 0x%h expected 0x%h",
                                          fmc_pkg::fmc_addr_t'(a + k), FMC_D_O, exp_word));
                end
                k++;
            end else begin
                assert (k == 0 && cyc < READ_WAIT_LIMIT) else begin
                    report_fail("FMC_NWAIT never rose or dropped in the middle of a read burst");
                end
            end
        end
        FMC_NE  = 1'b1;
        FMC_NOE = 1'b1;
    endtask

    // ==================================================
    // Stimulus table and run
    // ==================================================

    task automatic build_bursts();
        set_burst(0, 1'b1, 12'h100, 8, 2'b11, 1'b0);
        set_burst(1, 1'b0, 12'h100, 8, 2'b11, 1'b0);
        // Upper lane only so the lower byte must survive
        set_burst(2, 1'b1, 12'h100, 8, 2'b10, 1'b1);
        set_burst(3, 1'b0, 12'h100, 8, 2'b11, 1'b0);
        // Across the top of memory
        set_burst(4, 1'b1, 12'hFFE, 4, 2'b11, 1'b1);
        set_burst(5, 1'b0, 12'hFFE, 6, 2'b11, 1'b0);
        for (int i = 6; i < NUM_BURSTS; i++) begin
            set_burst(i, 1'($urandom_range(1, 0)),
                      fmc_pkg::fmc_addr_t'(12'h0F0 + $urandom_range(63, 0)),
                      int'($urandom_range(16, 1)),
                      fmc_pkg::fmc_be_t'($urandom_range(3, 1)), 1'b1);
        end
    endtask

    initial begin : main
        int budget;
        FMC_NE  = 1'b1;
        FMC_NL  = 1'b1;
        FMC_NOE = 1'b1;
        FMC_NWE = 1'b1;
        FMC_A   = '0;
        FMC_D_I = '0;
        FMC_NBL = '1;
        void'($urandom(22020));
        // RAM powers up cleared
        for (int i = 0; i < `FMC_MEM_WORDS; i++) begin
            ref_mem[i] = '0;
        end
        build_bursts();
        budget = RESET_CYCLES + WATCHDOG_MARGIN;
        for (int i = 0; i < NUM_BURSTS; i++) begin
            budget += bursts[i].len + `FMC_DATLAT + 8;
        end
        watchdog_cycles = budget;
        // First burst lowers NE on the falling edge after the fifth rising edge
        repeat (RESET_CYCLES - 1) begin
            @(negedge FMC_CLK_s);
            check_pin_rules(1'b1);
        end
        for (int i = 0; i < NUM_BURSTS; i++) begin
            if (bursts[i].is_write) begin
                apply_write_burst(i);
            end else begin
                apply_read_burst(i);
            end
        end
        @(negedge FMC_CLK_s);
        check_pin_rules(1'b1);
        $display("TB PASSED");
        $finish;
    end

    initial begin : watchdog
        wait (watchdog_cycles > 0);
        repeat (watchdog_cycles) @(posedge FMC_CLK_s);
        $display("Watchdog expired after %0d cycles, the bursts did not complete", watchdog_cycles);
        $display("TB FAILED");
        $fatal(1, "timeout");
    end

endmodule

// File: sources.f
+incdir+.
fmc_pkg.sv
fmc_burst_decode.sv
fmc_bram_access.sv
fmc_read_return.sv
psram_bram.sv
fmc_psram_top.sv
tb_clk_gen.sv
tb_fmc_psram.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        := tb_fmc_psram
FILELIST   := sources.f
VFLAGS     := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing
BUILD_DIR  := obj_dir
LOG        := run.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "TB PASSED" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
